//--- Bender.yml
package:
  name: branch_predictor

sources:
  - target: rtl
    files:
      - hdl/bp_pkg.sv
      - hdl/branch_predecode.sv
      - hdl/pattern_history_table.sv
      - hdl/guess_log_ram.sv
      - hdl/predict_unit.sv
      - hdl/branch_predictor_top.sv

  - target: test
    files:
      - verification/tb_branch_predictor.sv

//--- hdl/bp_pkg.sv
`default_nettype none

package bp_pkg;

    //////////////////////////////////////////////////////////////////////
    // Address and table geometry
    //////////////////////////////////////////////////////////////////////

    localparam int addr_width   = 32;

    // Pair index comes from pc[hash_depth+2:3]
    localparam int hash_depth   = 5;
    localparam int hash_entries = 1 << hash_depth;

    //////////////////////////////////////////////////////////////////////
    // History word and guess log entry
    //////////////////////////////////////////////////////////////////////

    localparam int para_width  = 10;
    localparam int hist_hi     = 9;
    localparam int hist_lo     = 8;
    localparam int num_ctrs    = 4;

    // Initial counter values for a freshly allocated entry
    localparam logic [1:0] ctr_weak_taken = 2'b10;
    localparam logic [1:0] ctr_weak_not   = 2'b01;

    // Slot 1 speculative history in [3:2], slot 2 in [1:0]
    localparam int guess_width = 4;

    //////////////////////////////////////////////////////////////////////
    // Instruction fields and info word
    //////////////////////////////////////////////////////////////////////

    localparam int offset_width = 26;

    typedef enum logic [5:0] {
        op_other  = 6'h00,
        op_jump   = 6'h02,
        op_branch = 6'h04
    } opcode_t;

    // Target word address sits above the two kind bits
    localparam int info_target_lsb = 2;
    localparam int info_uncond_bit = 1;
    localparam int info_cond_bit   = 0;

endpackage

`default_nettype wire

//--- hdl/branch_predecode.sv
`default_nettype none

module branch_predecode (
    input  wire [bp_pkg::addr_width-1:0] pc_now,
    input  wire [31:0]                   inst1,
    input  wire [31:0]                   inst2,
    output logic                         exist1,
    output logic                         exist2,
    output logic [bp_pkg::addr_width-1:0] info1,
    output logic [bp_pkg::addr_width-1:0] info2
);
    import bp_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Per-slot decode
    //////////////////////////////////////////////////////////////////////

    // Builds the info word for one slot, all zero for a non-branch
    function automatic logic [addr_width-1:0] decode_slot(
        input logic [addr_width-1:0] slot_pc,
        input logic [31:0]           inst
    );
        opcode_t               op;
        logic [addr_width-1:0] disp;
        logic [addr_width-1:0] target;
        logic [addr_width-1:0] info;
        op   = opcode_t'(inst[31:offset_width]);
        // Word offset, sign extended and scaled to bytes
        disp = {{(addr_width-offset_width-2){inst[offset_width-1]}},
                inst[offset_width-1:0], 2'b00};
        target = slot_pc + disp;
        info   = '0;
        case (op)
            op_jump: begin
                info[addr_width-1:info_target_lsb] =
                    target[addr_width-1:info_target_lsb];
                info[info_uncond_bit] = 1'b1;
            end
            op_branch: begin
                info[addr_width-1:info_target_lsb] =
                    target[addr_width-1:info_target_lsb];
                info[info_cond_bit] = 1'b1;
            end
            default: info = '0;
        endcase
        return info;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Slot addresses within the aligned pair
    //////////////////////////////////////////////////////////////////////

    logic [addr_width-1:0] slot1_pc;
    logic [addr_width-1:0] slot2_pc;

    assign slot1_pc = {pc_now[addr_width-1:3], 3'b000};
    assign slot2_pc = {pc_now[addr_width-1:3], 3'b100};

    assign info1 = decode_slot(slot1_pc, inst1);
    assign info2 = decode_slot(slot2_pc, inst2);

    // A slot is a branch exactly when one of its kind bits is set
    assign exist1 = info1[info_uncond_bit] | info1[info_cond_bit];
    assign exist2 = info2[info_uncond_bit] | info2[info_cond_bit];

endmodule

`default_nettype wire

//--- hdl/branch_predictor_top.sv
`default_nettype none

module branch_predictor_top (
    input  wire                           clk,
    input  wire                           rstn,
    input  wire                           en,
    input  wire [bp_pkg::addr_width-1:0]  pc_now,
    input  wire [31:0]                    inst1,
    input  wire [31:0]                    inst2,
    input  wire                           ex_vld,
    input  wire                           ex_wrong,
    input  wire [bp_pkg::addr_width-1:0]  ex_pc,
    input  wire                           ex_taken,
    output logic [bp_pkg::addr_width-1:0] pc_new,
    output logic                          branch,
    output logic                          reason
);
    import bp_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Interconnect
    //////////////////////////////////////////////////////////////////////

    logic                  exist1;
    logic                  exist2;
    logic [addr_width-1:0] info1;
    logic [addr_width-1:0] info2;
    logic                  past_vld1;
    logic                  past_vld2;
    logic [para_width-1:0] past1;
    logic [para_width-1:0] past2;

    // Decode the fetched pair
    branch_predecode branch_predecode_i (
        .pc_now (pc_now),
        .inst1  (inst1),
        .inst2  (inst2),
        .exist1 (exist1),
        .exist2 (exist2),
        .info1  (info1),
        .info2  (info2)
    );

    // Learned histories, trained from execute
    pattern_history_table pattern_history_table_i (
        .clk       (clk),
        .rstn      (rstn),
        .pc_now    (pc_now),
        .ex_vld    (ex_vld),
        .ex_pc     (ex_pc),
        .ex_taken  (ex_taken),
        .past_vld1 (past_vld1),
        .past_vld2 (past_vld2),
        .past1     (past1),
        .past2     (past2)
    );

    predict_unit predict_unit_i (
        .clk       (clk),
        .rstn      (rstn),
        .en        (en),
        .pc_now    (pc_now),
        .exist1    (exist1),
        .exist2    (exist2),
        .info1     (info1),
        .info2     (info2),
        .past_vld1 (past_vld1),
        .past_vld2 (past_vld2),
        .past1     (past1),
        .past2     (past2),
        .ex_wrong  (ex_wrong),
        .pc_new    (pc_new),
        .branch    (branch),
        .reason    (reason)
    );

endmodule

`default_nettype wire

//--- hdl/guess_log_ram.sv
`default_nettype none

module guess_log_ram (
    input  wire                            clk,
    input  wire                            wt_en,
    input  wire [bp_pkg::hash_depth-1:0]   wtaddr,
    input  wire [bp_pkg::guess_width-1:0]  wtdata,
    input  wire [bp_pkg::hash_depth-1:0]   raddr,
    output logic [bp_pkg::guess_width-1:0] rdata
);
    import bp_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////////////////////////

    // One entry per fetch pair
    logic [guess_width-1:0] mem [hash_entries];

    // Write lands at the clock edge
    always_ff @(posedge clk) begin
        if (wt_en) begin
            mem[wtaddr] <= wtdata;
        end
    end

    // Asynchronous read, so the predict path sees it in the same cycle
    assign rdata = mem[raddr];

endmodule

`default_nettype wire

//--- hdl/pattern_history_table.sv
`default_nettype none

module pattern_history_table (
    input  wire                           clk,
    input  wire                           rstn,
    input  wire [bp_pkg::addr_width-1:0]  pc_now,
    input  wire                           ex_vld,
    input  wire [bp_pkg::addr_width-1:0]  ex_pc,
    input  wire                           ex_taken,
    output logic                          past_vld1,
    output logic                          past_vld2,
    output logic [bp_pkg::para_width-1:0] past1,
    output logic [bp_pkg::para_width-1:0] past2
);
    import bp_pkg::*;

    logic [para_width-1:0]   hist1 [hash_entries];
    logic [para_width-1:0]   hist2 [hash_entries];
    logic [hash_entries-1:0] vld1;
    logic [hash_entries-1:0] vld2;

    logic [hash_depth-1:0]   rd_idx;
    logic [hash_depth-1:0]   ex_idx;
    logic                    ex_slot2;
    logic [para_width-1:0]   old_word;
    logic                    old_vld;
    logic [para_width-1:0]   new_word;

    //////////////////////////////////////////////////////////////////////
    // Training rule
    //////////////////////////////////////////////////////////////////////

    function automatic logic [para_width-1:0] train_word(
        input logic [para_width-1:0] old,
        input logic                  was_vld,
        input logic                  taken
    );
        logic [para_width-1:0] word;
        logic [1:0]            hist;
        logic [1:0]            ctr;
        word = old;
        hist = old[hist_hi:hist_lo];
        if (!was_vld) begin
            // Fresh entry, every counter weak toward the outcome
            for (int k = 0; k < num_ctrs; k++) begin
                word[2*k +: 2] = taken ? ctr_weak_taken : ctr_weak_not;
            end
            word[hist_hi:hist_lo] = {taken, taken};
        end else begin
            ctr = old[2*hist +: 2];
            if (taken && ctr != 2'b11) begin
                ctr = ctr + 2'd1;
            end else if (!taken && ctr != 2'b00) begin
                ctr = ctr - 2'd1;
            end
            word[2*hist +: 2]     = ctr;
            word[hist_hi:hist_lo] = {old[hist_lo], taken};
        end
        return word;
    endfunction

    // Read port, same cycle as pc_now
    assign rd_idx    = pc_now[hash_depth+2:3];
    assign past_vld1 = vld1[rd_idx];
    assign past_vld2 = vld2[rd_idx];
    assign past1     = hist1[rd_idx];
    assign past2     = hist2[rd_idx];

    // Write side from the execute stage
    assign ex_idx   = ex_pc[hash_depth+2:3];
    assign ex_slot2 = ex_pc[2];
    assign old_word = ex_slot2 ? hist2[ex_idx] : hist1[ex_idx];
    assign old_vld  = ex_slot2 ? vld2[ex_idx] : vld1[ex_idx];
    assign new_word = train_word(old_word, old_vld, ex_taken);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            vld1 <= '0;
            vld2 <= '0;
        end else if (ex_vld) begin
            if (ex_slot2) begin
                vld2[ex_idx] <= 1'b1;
            end else begin
                vld1[ex_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ex_vld) begin
            if (ex_slot2) begin
                hist2[ex_idx] <= new_word;
            end else begin
                hist1[ex_idx] <= new_word;
            end
        end
    end

    // Resolved pcs from execute are always word aligned
    ex_pc_aligned_a: assert property (@(posedge clk) disable iff (!rstn)
        ex_vld |-> ex_pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- hdl/predict_unit.sv
`default_nettype none

module predict_unit (
    input  wire                           clk,
    input  wire                           rstn,
    input  wire                           en,
    input  wire [bp_pkg::addr_width-1:0]  pc_now,
    input  wire                           exist1,
    input  wire                           exist2,
    input  wire [bp_pkg::addr_width-1:0]  info1,
    input  wire [bp_pkg::addr_width-1:0]  info2,
    input  wire                           past_vld1,
    input  wire                           past_vld2,
    input  wire [bp_pkg::para_width-1:0]  past1,
    input  wire [bp_pkg::para_width-1:0]  past2,
    input  wire                           ex_wrong,
    output logic [bp_pkg::addr_width-1:0] pc_new,
    output logic                          branch,
    output logic                          reason
);
    import bp_pkg::*;

    logic [hash_depth-1:0]   idx;
    logic [guess_width-1:0]  log_rdata;
    logic [guess_width-1:0]  log_wdata;
    logic [hash_entries-1:0] guess1;
    logic [hash_entries-1:0] guess2;

    logic [1:0] hist_used1;
    logic [1:0] hist_used2;
    logic       taken1;
    logic       taken2;
    logic       at_half;
    logic       set_guess1;
    logic       set_guess2;
    logic [addr_width-1:0] chosen;

    //////////////////////////////////////////////////////////////////////
    // Per-slot decision helpers
    //////////////////////////////////////////////////////////////////////

    // Direction bit of the counter that the history points at
    function automatic logic learned_dir(
        input logic [para_width-1:0] word,
        input logic [1:0]            hist
    );
        return word[2*hist + 1];
    endfunction

    function automatic logic slot_taken(
        input logic                  exist,
        input logic                  vld,
        input logic [para_width-1:0] word,
        input logic [1:0]            hist,
        input logic [addr_width-1:0] info,
        input logic [addr_width-1:0] pc
    );
        logic backward;
        backward = info[addr_width-1:info_target_lsb] < pc[addr_width-1:info_target_lsb];
        if (!exist) begin
            return 1'b0;
        end else if (vld) begin
            return learned_dir(word, hist);
        end else begin
            // Static rule takes jumps, then backward branches
            return info[info_uncond_bit] | backward;
        end
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Guess log
    //////////////////////////////////////////////////////////////////////

    assign idx = pc_now[hash_depth+2:3];

    guess_log_ram guess_log_ram_i (
        .clk    (clk),
        .wt_en  (en),
        .wtaddr (idx),
        .wtdata (log_wdata),
        .raddr  (idx),
        .rdata  (log_rdata)
    );

    // While guessing, the log replaces the table history
    assign hist_used1 = guess1[idx] ? log_rdata[3:2] : past1[hist_hi:hist_lo];
    assign hist_used2 = guess2[idx] ? log_rdata[1:0] : past2[hist_hi:hist_lo];

    assign taken1 = slot_taken(exist1, past_vld1, past1, hist_used1, info1, pc_now);
    assign taken2 = slot_taken(exist2, past_vld2, past2, hist_used2, info2, pc_now);

    //////////////////////////////////////////////////////////////////////
    // Outputs
    //////////////////////////////////////////////////////////////////////

    // Entering mid-pair, only slot 2 counts
    assign at_half = pc_now[2];
    assign branch  = at_half ? taken2 : (taken1 | taken2);
    assign reason  = at_half | (~taken1 & taken2);

    assign chosen = reason ? info2 : info1;
    assign pc_new = branch ? {chosen[addr_width-1:info_target_lsb], 2'b00}
                           : {pc_now[addr_width-1:3], 3'b000} + addr_width'(8);

    //////////////////////////////////////////////////////////////////////
    // Speculative state update
    //////////////////////////////////////////////////////////////////////

    // Shift the predicted outcome into each slot's history
    assign log_wdata = {hist_used1[0], branch & ~reason,
                        hist_used2[0], branch & reason};

    assign set_guess1 = ~at_half & exist1 & past_vld1 & info1[info_cond_bit];
    assign set_guess2 = ~taken1 & exist2 & past_vld2 & info2[info_cond_bit];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            guess1 <= '0;
            guess2 <= '0;
        end else if (en) begin
            if (ex_wrong) begin
                // Mispredict drops back to table history everywhere
                guess1 <= '0;
                guess2 <= '0;
            end else begin
                guess1[idx] <= guess1[idx] | set_guess1;
                guess2[idx] <= guess2[idx] | set_guess2;
            end
        end
    end

    // A guess flag only ever sits on top of a trained table entry
    guess_needs_table_a: assert property (@(posedge clk) disable iff (!rstn)
        (!guess1[idx] || past_vld1) && (!guess2[idx] || past_vld2));

    // A redirect from slot 2 needs a decoded branch there
    reason_needs_exist2_a: assert property (@(posedge clk) disable iff (!rstn)
        (branch && reason) |-> exist2);

endmodule

`default_nettype wire

//--- list.f
hdl/bp_pkg.sv
hdl/branch_predecode.sv
hdl/pattern_history_table.sv
hdl/guess_log_ram.sv
hdl/predict_unit.sv
hdl/branch_predictor_top.sv
verification/tb_branch_predictor.sv

//--- verification/tb_branch_predictor.sv
`default_nettype none

module tb_branch_predictor;
    import bp_pkg::*;

    localparam int num_tests      = 5;
    localparam int timeout_cycles = num_tests * 200 + 100;

    logic        clk;
    logic        rstn;
    logic        en;
    logic [31:0] pc_now;
    logic [31:0] inst1;
    logic [31:0] inst2;
    logic        ex_vld;
    logic        ex_wrong;
    logic [31:0] ex_pc;
    logic        ex_taken;
    logic [31:0] pc_new;
    logic        branch;
    logic        reason;
    integer      seed;

    //////////////////////////////////////////////////////////////////////
    // Reference model state and last results
    //////////////////////////////////////////////////////////////////////

    logic [para_width-1:0]   m_hist1 [hash_entries];
    logic [para_width-1:0]   m_hist2 [hash_entries];
    logic [guess_width-1:0]  m_log [hash_entries];
    logic [hash_entries-1:0] m_vld1;
    logic [hash_entries-1:0] m_vld2;
    logic [hash_entries-1:0] m_g1;
    logic [hash_entries-1:0] m_g2;

    logic [31:0] exp_pc;
    logic        exp_branch;
    logic        exp_reason;
    logic        e_taken1;
    logic [1:0]  e_hist1;
    logic [1:0]  e_hist2;
    logic        e_set1;
    logic        e_set2;
    logic [31:0] act_pc;
    logic        act_branch;
    logic        act_reason;

    // Pairs trained in the training test, reused later
    logic [31:0] trained_pc [4];
    logic [31:0] trained_i1 [4];
    logic [31:0] trained_i2 [4];

    branch_predictor_top branch_predictor_top_i (
        .clk      (clk),
        .rstn     (rstn),
        .en       (en),
        .pc_now   (pc_now),
        .inst1    (inst1),
        .inst2    (inst2),
        .ex_vld   (ex_vld),
        .ex_wrong (ex_wrong),
        .ex_pc    (ex_pc),
        .ex_taken (ex_taken),
        .pc_new   (pc_new),
        .branch   (branch),
        .reason   (reason)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string test_name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s %s expected %h actual %h",
                     test_name, what, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "Mismatch in %s", test_name);
        end
    endtask

    function automatic logic [31:0] make_inst(input opcode_t op, input logic [25:0] off);
        return {op, off};
    endfunction

    task automatic random_other(output logic [31:0] inst);
        inst = $random(seed);
        while (inst[31:26] == op_jump || inst[31:26] == op_branch) begin
            inst = $random(seed);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Model rules
    //////////////////////////////////////////////////////////////////////

    task automatic slot_decode(input logic [31:0] slot_pc, input logic [31:0] inst,
                               output logic exist, output logic uncond,
                               output logic [31:0] target);
        logic [31:0] disp;
        exist  = (inst[31:26] == op_jump) || (inst[31:26] == op_branch);
        uncond = (inst[31:26] == op_jump);
        disp   = {{4{inst[25]}}, inst[25:0], 2'b00};
        target = slot_pc + disp;
    endtask

    function automatic logic slot_decision(input logic [31:0] pc, input logic exist,
                                           input logic uncond, input logic [31:0] target,
                                           input logic vld, input logic [9:0] word,
                                           input logic [1:0] hist);
        if (!exist)
            return 1'b0;
        if (vld)
            return word[2*hist+1];
        if (uncond)
            return 1'b1;
        return target[31:2] < pc[31:2];
    endfunction

    task automatic model_eval(input logic [31:0] pc, input logic [31:0] i1,
                              input logic [31:0] i2);
        logic [4:0]  idx;
        logic        ex1, ex2, un1, un2, t2;
        logic [31:0] tg1, tg2;
        idx = pc[hash_depth+2:3];
        slot_decode({pc[31:3], 3'b000}, i1, ex1, un1, tg1);
        slot_decode({pc[31:3], 3'b100}, i2, ex2, un2, tg2);
        e_hist1  = m_g1[idx] ? m_log[idx][3:2] : m_hist1[idx][9:8];
        e_hist2  = m_g2[idx] ? m_log[idx][1:0] : m_hist2[idx][9:8];
        e_taken1 = slot_decision(pc, ex1, un1, tg1, m_vld1[idx], m_hist1[idx], e_hist1);
        t2       = slot_decision(pc, ex2, un2, tg2, m_vld2[idx], m_hist2[idx], e_hist2);
        exp_branch = pc[2] ? t2 : (e_taken1 | t2);
        exp_reason = pc[2] | (!e_taken1 && t2);
        if (exp_branch)
            exp_pc = exp_reason ? tg2 : tg1;
        else
            exp_pc = {pc[31:3], 3'b000} + 32'd8;
        e_set1 = ex1 && !un1 && m_vld1[idx] && !pc[2];
        e_set2 = ex2 && !un2 && m_vld2[idx] && !e_taken1;
    endtask

    task automatic model_guess_update(input logic [31:0] pc, input logic wrong);
        logic [4:0] idx;
        idx = pc[hash_depth+2:3];
        m_log[idx] = {e_hist1[0], exp_branch && !exp_reason,
                      e_hist2[0], exp_branch && exp_reason};
        if (wrong) begin
            m_g1 = '0;
            m_g2 = '0;
        end else begin
            m_g1[idx] = m_g1[idx] | e_set1;
            m_g2[idx] = m_g2[idx] | e_set2;
        end
    endtask

    task automatic model_train(input logic [31:0] addr, input logic taken);
        logic [4:0] idx;
        logic [9:0] word;
        logic [1:0] h;
        logic [1:0] c;
        idx  = addr[hash_depth+2:3];
        word = addr[2] ? m_hist2[idx] : m_hist1[idx];
        if (!(addr[2] ? m_vld2[idx] : m_vld1[idx])) begin
            word = taken ? 10'b11_10_10_10_10 : 10'b00_01_01_01_01;
        end else begin
            h = word[9:8];
            c = word[2*h +: 2];
            if (taken && c != 2'b11)
                c = c + 2'd1;
            else if (!taken && c != 2'b00)
                c = c - 2'd1;
            word[2*h +: 2] = c;
            word[9:8]      = {word[8], taken};
        end
        if (addr[2]) begin
            m_hist2[idx] = word;
            m_vld2[idx]  = 1'b1;
        end else begin
            m_hist1[idx] = word;
            m_vld1[idx]  = 1'b1;
        end
    endtask

    // One fetch cycle, checked at the falling edge
    task automatic step(input string test_name, input logic [31:0] pc,
                        input logic [31:0] i1, input logic [31:0] i2,
                        input logic en_v, input logic ex_vld_v, input logic ex_wrong_v,
                        input logic [31:0] ex_pc_v, input logic ex_taken_v);
        @(posedge clk);
        pc_now   <= pc;
        inst1    <= i1;
        inst2    <= i2;
        en       <= en_v;
        ex_vld   <= ex_vld_v;
        ex_wrong <= ex_wrong_v;
        ex_pc    <= ex_pc_v;
        ex_taken <= ex_taken_v;
        @(negedge clk);
        act_pc     = pc_new;
        act_branch = branch;
        act_reason = reason;
        model_eval(pc, i1, i2);
        check_value(test_name, "branch", exp_branch, act_branch);
        check_value(test_name, "reason", exp_reason, act_reason);
        check_value(test_name, "pc_new", exp_pc, act_pc);
        // Committed by the coming rising edge
        if (en_v)
            model_guess_update(pc, ex_wrong_v);
        if (ex_vld_v)
            model_train(ex_pc_v, ex_taken_v);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_no_branches();
        logic [31:0] pc, i1, i2;
        for (int n = 0; n < 12; n++) begin
            pc      = $random(seed);
            pc[1:0] = 2'b00;
            pc[2]   = n[0];
            random_other(i1);
            random_other(i2);
            step("no_branches", pc, i1, i2, 1'b1, 1'b0, 1'b0, 32'h0, 1'b0);
            check_value("no_branches", "branch", 32'd0, act_branch);
        end
    endtask

    task automatic test_static_rules();
        logic [31:0] pc, other, r;
        logic [31:0] jmp, bwd, fwd;
        pc = 32'h4000_0000 | ($random(seed) & 32'h0fff_fff8);
        random_other(other);
        r   = $random(seed);
        jmp = make_inst(op_jump, r[25:0]);
        r   = $random(seed) & 32'h3ff;
        bwd = make_inst(op_branch, 26'd0 - r[25:0] - 26'd1);
        fwd = make_inst(op_branch, r[25:0] + 26'd1);
        step("static_jump", pc, jmp, other, 1'b1, 1'b0, 1'b0, 32'h0, 1'b0);
        check_value("static_jump", "branch", 32'd1, act_branch);
        step("static_backward", pc, bwd, other, 1'b1, 1'b0, 1'b0, 32'h0, 1'b0);
        check_value("static_backward", "branch", 32'd1, act_branch);
        step("static_forward", pc, fwd, other, 1'b1, 1'b0, 1'b0, 32'h0, 1'b0);
        check_value("static_forward", "branch", 32'd0, act_branch);
        step("static_both", pc, jmp, bwd, 1'b1, 1'b0, 1'b0, 32'h0, 1'b0);
        check_value("static_both", "reason", 32'd0, act_reason);
        step("static_half", pc | 32'd4, jmp, other, 1'b1, 1'b0, 1'b0, 32'h0, 1'b0);
        check_value("static_half", "branch", 32'd0, act_branch);
        step("static_half", pc | 32'd4, other, jmp, 1'b1, 1'b0, 1'b0, 32'h0, 1'b0);
        check_value("static_half", "reason", 32'd1, act_reason);
    endtask

    task automatic test_training();
        logic [31:0] pc, r;
        for (int k = 0; k < 4; k++) begin
            pc = 32'h1000_0000 | ($random(seed) & 32'h00ff_ff00) | (32'(k) << 3);
            trained_pc[k] = pc;
            r = $random(seed);
            trained_i1[k] = make_inst(op_branch, r[25:0]);
            r = $random(seed);
            trained_i2[k] = make_inst(op_branch, r[25:0]);
            for (int n = 0; n < 6; n++) begin
                r = $random(seed);
                step("training", pc, trained_i1[k], trained_i2[k],
                     1'b0, 1'b1, 1'b0, pc, r[0]);
                step("training", pc, trained_i1[k], trained_i2[k],
                     1'b0, 1'b1, 1'b0, pc | 32'd4, r[1]);
            end
            step("training", pc, trained_i1[k], trained_i2[k],
                 1'b0, 1'b0, 1'b0, 32'h0, 1'b0);
        end
    endtask

    task automatic test_guess_mode();
        for (int n = 0; n < 8; n++) begin
            step("guess_mode", trained_pc[n % 2], trained_i1[n % 2], trained_i2[n % 2],
                 1'b1, 1'b0, 1'b0, 32'h0, 1'b0);
        end
        // Mispredict drops every guess flag
        step("guess_mode", trained_pc[0], trained_i1[0], trained_i2[0],
             1'b1, 1'b0, 1'b1, 32'h0, 1'b0);
        for (int n = 0; n < 2; n++) begin
            step("guess_recover", trained_pc[n], trained_i1[n], trained_i2[n],
                 1'b0, 1'b0, 1'b0, 32'h0, 1'b0);
        end
    endtask

    task automatic test_fetch_stall();
        logic [31:0] first_pc;
        logic        first_br;
        logic        first_rs;
        for (int n = 0; n < 4; n++) begin
            step("fetch_stall", trained_pc[2], trained_i1[2], trained_i2[2],
                 n < 3, 1'b0, 1'b0, 32'h0, 1'b0);
        end
        first_pc = act_pc;
        first_br = act_branch;
        first_rs = act_reason;
        repeat (4) begin
            step("fetch_stall", trained_pc[2], trained_i1[2], trained_i2[2],
                 1'b0, 1'b0, 1'b0, 32'h0, 1'b0);
            check_value("fetch_stall", "repeat pc_new", first_pc, act_pc);
            check_value("fetch_stall", "repeat branch", first_br, act_branch);
            check_value("fetch_stall", "repeat reason", first_rs, act_reason);
        end
    endtask

    initial begin
        seed     = 44217;
        rstn     = 1'b0;
        en       = 1'b0;
        pc_now   = '0;
        inst1    = '0;
        inst2    = '0;
        ex_vld   = 1'b0;
        ex_wrong = 1'b0;
        ex_pc    = '0;
        ex_taken = 1'b0;
        m_vld1   = '0;
        m_vld2   = '0;
        m_g1     = '0;
        m_g2     = '0;
        for (int i = 0; i < hash_entries; i++) begin
            m_hist1[i] = '0;
            m_hist2[i] = '0;
            m_log[i]   = '0;
        end
        repeat (10) @(posedge clk);
        rstn <= 1'b1;
        test_no_branches();
        test_static_rules();
        test_training();
        test_guess_mode();
        test_fetch_stall();
        $display("Simulation PASSED");
        $finish;
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("Timeout: tests did not complete within %0d cycles", timeout_cycles);
        $display("Simulation FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire
